//--- list.f
verilog/systemPkg.sv
verilog/sdWordReader.sv
verilog/bootLoader.sv
verilog/wordRam.sv
verilog/buttonDebouncer.sv
verilog/busDecoder.sv
verilog/boardTop.sv
tests/sdCardModel.sv
tests/boardTb.sv

//--- Makefile
# Verilator build and run for the board controller

VERILATOR ?= verilator
TOP       ?= boardTb
SEED      ?= 32'hfcb4d742
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
GFLAGS    ?= -GSeed="$(SEED)"

SOURCES := $(shell grep -v '^+' list.f)
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run check clean

all: check

$(SIM): list.f $(SOURCES)
	$(VERILATOR) --binary --timing --assert -Mdir $(BUILD_DIR) \
		--top-module $(TOP) $(GFLAGS) -f list.f

run: $(SIM)
	$(SIM) > $(LOG) 2>&1 || echo '** FAIL **' >> $(LOG)
	@cat $(LOG)

check: run
	@if grep -qF '** FAIL **' $(LOG); then \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	else \
		echo "Simulation passed"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tests/boardTb.sv
`timescale 1ns/1ns

module boardTb import systemPkg::*; #(
    parameter logic [31:0] Seed = 32'hfcb4d742
);

    localparam int ClockPeriod    = 40;
    localparam int ResetCycles    = 5;
    localparam int StimDelay      = 2;
    localparam int MaxLength      = 64;
    localparam int ImageBits      = $clog2(MaxLength + 1);
    localparam int TxnCount       = 400;
    localparam int LedWrites      = 8;
    localparam int ButtonRounds   = 12;
    // Upper bound on one card word read including loader turnaround
    localparam int WordReadCycles = 150;

    logic                   CPUClock;
    logic                   rstN;
    logic                   sdCs;
    logic                   sdClk;
    logic                   sdMosi;
    logic                   sdMiso;
    logic [ButtonCount-1:0] btn;
    logic [7:0]             led;
    logic [31:0]            cpuAddress;
    logic [31:0]            cpuWriteData;
    logic                   cpuRead;
    logic                   cpuWrite;
    logic [31:0]            cpuReadData;
    logic                   cpuDone;
    logic                   cpuHold;
    logic                   protocolError;
    logic [31:0]            cardImage [MaxLength + 1];

    // Reference model
    logic [31:0]            refRam [RamWords];
    bit                     refValid [RamWords];
    logic [RamAddrBits-1:0] knownAddrs [$];
    logic [7:0]             refLed;
    int                     imageLength;
    int                     dataErrors;
    int                     timingErrors;
    int                     otherErrors;

    boardTop UUT (
        .CPUClock(CPUClock),
        .rstN(rstN),
        .sdCs(sdCs),
        .sdClk(sdClk),
        .sdMosi(sdMosi),
        .sdMiso(sdMiso),
        .btn(btn),
        .led(led),
        .cpuAddress(cpuAddress),
        .cpuWriteData(cpuWriteData),
        .cpuRead(cpuRead),
        .cpuWrite(cpuWrite),
        .cpuReadData(cpuReadData),
        .cpuDone(cpuDone),
        .cpuHold(cpuHold)
    );

    sdCardModel #(.ImageWords(MaxLength + 1)) card (
        .sdCs(sdCs),
        .sdClk(sdClk),
        .sdMosi(sdMosi),
        .sdMiso(sdMiso),
        .image(cardImage),
        .protocolError(protocolError)
    );

    initial CPUClock = 1'b0;
    always #(ClockPeriod / 2) CPUClock = ~CPUClock;

    task automatic finishRun();
        $display("Errors: data %0d, timing %0d, other %0d",
                 dataErrors, timingErrors, otherErrors);
        if (dataErrors + timingErrors + otherErrors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    endtask

    // Idle cycles where no done pulse may show up
    task automatic stepCycles(input int count);
        repeat (count) begin
            @(posedge CPUClock);
            #StimDelay;
            if (cpuDone) begin
                timingErrors++;
                $display("cpuDone pulsed in a cycle without a preceding strobe");
            end
        end
    endtask

    // One strobe followed by a wait for cpuDone and its latency
    task automatic busAccess(input logic isWrite, input logic [31:0] address,
                             input logic [31:0] data, output logic [31:0] readData);
        int waitCycles;
        cpuAddress   = address;
        cpuWriteData = data;
        cpuWrite     = isWrite;
        cpuRead      = !isWrite;
        @(posedge CPUClock);
        #StimDelay;
        cpuRead    = 1'b0;
        cpuWrite   = 1'b0;
        waitCycles = 1;
        while (!cpuDone && waitCycles < 8) begin
            @(posedge CPUClock);
            #StimDelay;
            waitCycles++;
        end
        readData = cpuReadData;
        if (!cpuDone) begin
            timingErrors++;
            $display("No cpuDone within 8 cycles of the strobe to address %08h", address);
        end else if (waitCycles != 1) begin
            timingErrors++;
            $display("[FAIL] cpuDone latency at %08h: expected %0h, got %0h",
                     address, 1, waitCycles);
        end
    endtask

    // Random upper bits with only the IO bit of this access type kept clear
    function automatic logic [31:0] ramByteAddress(input logic [RamAddrBits-1:0] index,
                                                   input logic forWrite);
        logic [31:0] address;
        address = $urandom & 32'hffff_f000;
        if (forWrite) begin
            address[IoLedBit] = 1'b0;
        end else begin
            address[IoButtonBit] = 1'b0;
        end
        address[RamAddrBits+1:2] = index;
        return address;
    endfunction

    function automatic logic [31:0] buttonAddress();
        logic [31:0] address;
        address              = $urandom;
        address[IoButtonBit] = 1'b1;
        address[1:0]         = 2'b00;
        return address;
    endfunction

    task automatic readAndCompare(input logic [31:0] address, input logic [31:0] expected);
        logic [31:0] got;
        busAccess(1'b0, address, 32'h0, got);
        if (got !== expected) begin
            dataErrors++;
            $display("[FAIL] cpuReadData at %08h: expected %08h, got %08h",
                     address, expected, got);
        end
    endtask

    task automatic writeWord(input logic [RamAddrBits-1:0] index, input logic [31:0] data);
        logic [31:0] unused;
        busAccess(1'b1, ramByteAddress(index, 1'b1), data, unused);
        refRam[index] = data;
        if (!refValid[index]) begin
            knownAddrs.push_back(index);
        end
        refValid[index] = 1'b1;
    endtask

    // Watchdog sized from the image length and the traffic that follows
    initial begin
        int budget;
        wait (imageLength != 0);
        budget = ResetCycles + ResetHoldCycles
               + 2 * (imageLength + 1) * WordReadCycles
               + 4 * (imageLength + TxnCount + LedWrites)
               + 4 * ButtonRounds * (DebounceCycles + 8) + 100;
        repeat (budget) @(posedge CPUClock);
        otherErrors++;
        $display("Watchdog expired after %0d cycles before the tests finished", budget);
        finishRun();
    end

    initial begin
        logic [RamAddrBits-1:0] index;
        logic [31:0]            data;
        logic [31:0]            address;
        logic [31:0]            unused;
        logic [ButtonCount-1:0] refButtons;
        logic [ButtonCount-1:0] nextButtons;
        rstN         = 1'b0;
        btn          = '0;
        cpuAddress   = '0;
        cpuWriteData = '0;
        cpuRead      = 1'b0;
        cpuWrite     = 1'b0;
        dataErrors   = 0;
        timingErrors = 0;
        otherErrors  = 0;
        refLed       = 8'h00;
        refButtons   = '0;
        void'($urandom(Seed));

        // Card image with the length in word 0
        cardImage[0] = 32'h0;
        for (int k = 1; k <= MaxLength; k++) begin
            cardImage[ImageBits'(k)] = $urandom;
        end
        imageLength  = int'($urandom_range(MaxLength, 1));
        cardImage[0] = 32'(imageLength);

        repeat (ResetCycles) @(posedge CPUClock);
        #StimDelay;
        rstN = 1'b1;

        // Boot hold and LED patterns
        if (cpuHold !== 1'b1) begin
            otherErrors++;
            $display("[FAIL] cpuHold after reset: expected 1, got %h", cpuHold);
        end
        while (cpuHold === 1'b1) begin
            if (led !== LedWaitPattern && led !== LedSizePattern && led !== LedLoadPattern) begin
                dataErrors++;
                $display("[FAIL] led during boot: expected a boot pattern, got %02h", led);
            end
            @(posedge CPUClock);
            #StimDelay;
        end
        if (led !== refLed) begin
            dataErrors++;
            $display("[FAIL] led after boot: expected %02h, got %02h", refLed, led);
        end

        // Card word k+1 sits in RAM word k
        for (int k = 0; k < imageLength; k++) begin
            index           = RamAddrBits'(k);
            refRam[index]   = cardImage[ImageBits'(k + 1)];
            refValid[index] = 1'b1;
            knownAddrs.push_back(index);
            readAndCompare(ramByteAddress(index, 1'b0), refRam[index]);
        end

        // Random RAM traffic
        for (int n = 0; n < TxnCount; n++) begin
            if ($urandom_range(1, 0) == 0) begin
                writeWord(RamAddrBits'($urandom), $urandom);
            end else begin
                index = knownAddrs[$urandom_range(knownAddrs.size() - 1, 0)];
                readAndCompare(ramByteAddress(index, 1'b0), refRam[index]);
            end
            if ($urandom_range(3, 0) == 0) begin
                stepCycles(1);
            end
        end

        // LED register writes leave RAM behind the same low bits intact
        for (int n = 0; n < LedWrites; n++) begin
            index   = knownAddrs[$urandom_range(knownAddrs.size() - 1, 0)];
            address = ramByteAddress(index, 1'b0);
            address[IoLedBit] = 1'b1;
            data    = $urandom;
            busAccess(1'b1, address, data, unused);
            refLed = data[7:0];
            if (led !== refLed) begin
                dataErrors++;
                $display("[FAIL] led: expected %02h, got %02h", refLed, led);
            end
            readAndCompare(address, refRam[index]);
        end

        // Button rounds where odd ones glitch the changed channels back inside the lockout
        for (int round = 0; round < ButtonRounds; round++) begin
            nextButtons = refButtons ^ ButtonCount'($urandom_range((1 << ButtonCount) - 1, 1));
            btn = nextButtons;
            if (round % 2 == 1) begin
                stepCycles(4);
                btn = refButtons;
                stepCycles(2);
                btn = nextButtons;
                // Without the lockout the glitch would show on the port here
                stepCycles(1);
                readAndCompare(buttonAddress(), 32'(nextButtons));
                stepCycles(DebounceCycles);
            end else begin
                stepCycles(DebounceCycles + 6);
            end
            refButtons = nextButtons;
            readAndCompare(buttonAddress(), 32'(refButtons));
        end

        if (protocolError) begin
            otherErrors++;
            $display("The card model received a malformed or out of range read command");
        end
        finishRun();
    end

endmodule

//--- tests/sdCardModel.sv
`timescale 1ns/1ns

module sdCardModel import systemPkg::*; #(
    parameter int ImageWords = 65
) (
    input  logic        sdCs,
    input  logic        sdClk,
    input  logic        sdMosi,
    output logic        sdMiso,
    input  logic [31:0] image [ImageWords],
    output logic        protocolError
);

    localparam int IndexBits = $clog2(ImageWords);

    logic [39:0]          command;
    logic [31:0]          reply;
    logic [6:0]           bitCount;
    logic [IndexBits-1:0] wordIndex;

    initial begin
        command       = '0;
        reply         = '1;
        bitCount      = '0;
        protocolError = 1'b0;
    end

    assign sdMiso    = reply[31];
    assign wordIndex = command[IndexBits-1:0];

    // Opcode and address come in on the rising edge of sdClk
    always @(negedge sdCs or posedge sdClk) begin
        if (!sdClk) begin
            bitCount <= '0;
        end else if (!sdCs) begin
            if (bitCount < 7'd40) begin
                command <= {command[38:0], sdMosi};
            end
            bitCount <= bitCount + 7'd1;
        end
    end

    // Reply bits change while sdClk is low, MSB first
    always @(negedge sdClk) begin
        if (!sdCs && bitCount == 7'd40) begin
            if (command[39:32] != SdReadOpcode || command[31:0] >= ImageWords) begin
                protocolError <= 1'b1;
                reply         <= '0;
            end else begin
                reply <= image[wordIndex];
            end
        end else if (!sdCs && bitCount > 7'd40) begin
            reply <= {reply[30:0], 1'b1};
        end
    end

endmodule

//--- verilog/boardTop.sv
`timescale 1ns/1ns

module boardTop import systemPkg::*; (
    input  logic                   CPUClock,
    input  logic                   rstN,
    output logic                   sdCs,
    output logic                   sdClk,
    output logic                   sdMosi,
    input  logic                   sdMiso,
    input  logic [ButtonCount-1:0] btn,
    output logic [7:0]             led,
    input  logic [31:0]            cpuAddress,
    input  logic [31:0]            cpuWriteData,
    input  logic                   cpuRead,
    input  logic                   cpuWrite,
    output logic [31:0]            cpuReadData,
    output logic                   cpuDone,
    output logic                   cpuHold
);

    // Loader to card reader
    logic                   readStart;
    logic [31:0]            readAddress;
    logic                   readBusy;
    logic                   readValid;
    logic [31:0]            readData;

    // Loader to bus
    logic                   loadWrite;
    logic [RamAddrBits-1:0] loadAddress;
    logic [31:0]            loadData;
    logic [7:0]             bootLeds;

    // Bus to RAM
    logic                   ramRead;
    logic                   ramWrite;
    logic [RamAddrBits-1:0] ramAddress;
    logic [31:0]            ramWriteData;
    logic [31:0]            ramReadData;
    logic                   ramReadReady;
    logic                   ramWriteDone;

    logic [ButtonCount-1:0] buttons;

    sdWordReader reader (
        .CPUClock(CPUClock),
        .rstN(rstN),
        .start(readStart),
        .wordAddress(readAddress),
        .busy(readBusy),
        .wordValid(readValid),
        .wordData(readData),
        .sdCs(sdCs),
        .sdClk(sdClk),
        .sdMosi(sdMosi),
        .sdMiso(sdMiso)
    );

    bootLoader loader (
        .CPUClock(CPUClock),
        .rstN(rstN),
        .busy(readBusy),
        .wordValid(readValid),
        .wordData(readData),
        .start(readStart),
        .wordAddress(readAddress),
        .loadWrite(loadWrite),
        .loadAddress(loadAddress),
        .loadData(loadData),
        .holdCpu(cpuHold),
        .bootLeds(bootLeds)
    );

    wordRam ram (
        .CPUClock(CPUClock),
        .read(ramRead),
        .write(ramWrite),
        .address(ramAddress),
        .writeData(ramWriteData),
        .readData(ramReadData),
        .readReady(ramReadReady),
        .writeDone(ramWriteDone)
    );

    buttonDebouncer debouncer (
        .CPUClock(CPUClock),
        .rstN(rstN),
        .btn(btn),
        .buttons(buttons)
    );

    busDecoder decoder (
        .CPUClock(CPUClock),
        .rstN(rstN),
        .holdCpu(cpuHold),
        .bootLeds(bootLeds),
        .loadWrite(loadWrite),
        .loadAddress(loadAddress),
        .loadData(loadData),
        .cpuAddress(cpuAddress),
        .cpuWriteData(cpuWriteData),
        .cpuRead(cpuRead),
        .cpuWrite(cpuWrite),
        .cpuReadData(cpuReadData),
        .cpuDone(cpuDone),
        .led(led),
        .ramRead(ramRead),
        .ramWrite(ramWrite),
        .ramAddress(ramAddress),
        .ramWriteData(ramWriteData),
        .ramReadData(ramReadData),
        .ramReadReady(ramReadReady),
        .ramWriteDone(ramWriteDone),
        .buttons(buttons)
    );

endmodule

//--- verilog/busDecoder.sv
`timescale 1ns/1ns

module busDecoder import systemPkg::*; (
    input  logic                   CPUClock,
    input  logic                   rstN,
    input  logic                   holdCpu,
    input  logic [7:0]             bootLeds,
    input  logic                   loadWrite,
    input  logic [RamAddrBits-1:0] loadAddress,
    input  logic [31:0]            loadData,
    input  logic [31:0]            cpuAddress,
    input  logic [31:0]            cpuWriteData,
    input  logic                   cpuRead,
    input  logic                   cpuWrite,
    output logic [31:0]            cpuReadData,
    output logic                   cpuDone,
    output logic [7:0]             led,
    output logic                   ramRead,
    output logic                   ramWrite,
    output logic [RamAddrBits-1:0] ramAddress,
    output logic [31:0]            ramWriteData,
    input  logic [31:0]            ramReadData,
    input  logic                   ramReadReady,
    input  logic                   ramWriteDone,
    input  logic [ButtonCount-1:0] buttons
);

    logic                   buttonAccess;
    logic                   ledAccess;
    logic                   cpuRamAccess;
    logic                   ramPendingQ;
    logic                   ioPendingQ;
    logic                   buttonSelQ;
    logic [7:0]             ledReg;
    logic [ButtonCount-1:0] buttonData;

    // Address decode once the loader has let go
    assign buttonAccess = !holdCpu && cpuRead && cpuAddress[IoButtonBit];
    assign ledAccess    = !holdCpu && cpuWrite && cpuAddress[IoLedBit];
    assign cpuRamAccess = !holdCpu && (cpuRead || cpuWrite) && !buttonAccess && !ledAccess;

    // RAM master select
    assign ramRead      = cpuRamAccess && cpuRead;
    assign ramWrite     = holdCpu ? loadWrite : (cpuRamAccess && cpuWrite);
    assign ramAddress   = holdCpu ? loadAddress : cpuAddress[RamAddrBits+1:2];
    assign ramWriteData = holdCpu ? loadData : cpuWriteData;

    always_ff @(posedge CPUClock or negedge rstN) begin
        if (!rstN) begin
            ramPendingQ <= 1'b0;
            ioPendingQ  <= 1'b0;
            buttonSelQ  <= 1'b0;
            ledReg      <= '0;
        end else begin
            ramPendingQ <= cpuRamAccess;
            ioPendingQ  <= buttonAccess || ledAccess;
            buttonSelQ  <= buttonAccess;
            if (ledAccess) begin
                ledReg <= cpuWriteData[7:0];
            end
        end
    end

    // Button value captured with the read so it lines up with RAM data
    always_ff @(posedge CPUClock) begin
        if (buttonAccess) begin
            buttonData <= buttons;
        end
    end

    assign cpuDone     = ioPendingQ || (ramPendingQ && (ramReadReady || ramWriteDone));
    assign cpuReadData = buttonSelQ ? {{(32 - ButtonCount){1'b0}}, buttonData} : ramReadData;
    assign led         = holdCpu ? bootLeds : ledReg;

    assert property (@(posedge CPUClock) disable iff (!rstN) !(cpuRead && cpuWrite));

    // Processor must stay quiet during boot
    assert property (@(posedge CPUClock) disable iff (!rstN)
        holdCpu |-> !(cpuRead || cpuWrite));

endmodule

//--- verilog/buttonDebouncer.sv
`timescale 1ns/1ns

module buttonDebouncer import systemPkg::*; (
    input  logic                   CPUClock,
    input  logic                   rstN,
    input  logic [ButtonCount-1:0] btn,
    output logic [ButtonCount-1:0] buttons
);

    logic [ButtonCount-1:0]  syncA;
    logic [ButtonCount-1:0]  syncB;
    logic [DebounceBits-1:0] lockout [ButtonCount];

    always_ff @(posedge CPUClock or negedge rstN) begin
        if (!rstN) begin
            syncA   <= '0;
            syncB   <= '0;
            buttons <= '0;
            for (int i = 0; i < ButtonCount; i++) begin
                lockout[i] <= '0;
            end
        end else begin
            syncA <= btn;
            syncB <= syncA;
            for (int i = 0; i < ButtonCount; i++) begin
                if (lockout[i] == '0) begin
                    // Idle channel takes the new level and locks
                    if (syncB[i] != buttons[i]) begin
                        buttons[i] <= syncB[i];
                        lockout[i] <= DebounceBits'(1);
                    end
                end else if (lockout[i] == DebounceBits'(DebounceCycles)) begin
                    lockout[i] <= '0;
                end else begin
                    lockout[i] <= lockout[i] + 1'b1;
                end
            end
        end
    end

endmodule

//--- verilog/wordRam.sv
`timescale 1ns/1ns

module wordRam import systemPkg::*; (
    input  logic                   CPUClock,
    input  logic                   read,
    input  logic                   write,
    input  logic [RamAddrBits-1:0] address,
    input  logic [31:0]            writeData,
    output logic [31:0]            readData,
    output logic                   readReady,
    output logic                   writeDone
);

    logic [31:0] mem [RamWords];

    // Storage and registered read port
    always_ff @(posedge CPUClock) begin
        if (write) begin
            mem[address] <= writeData;
        end
        if (read) begin
            readData <= mem[address];
        end
    end

    // Done pulses one cycle after the request
    always_ff @(posedge CPUClock) begin
        readReady <= read;
        writeDone <= write;
    end

endmodule

//--- verilog/bootLoader.sv
`timescale 1ns/1ns

module bootLoader import systemPkg::*; (
    input  logic                   CPUClock,
    input  logic                   rstN,
    input  logic                   busy,
    input  logic                   wordValid,
    input  logic [31:0]            wordData,
    output logic                   start,
    output logic [31:0]            wordAddress,
    output logic                   loadWrite,
    output logic [RamAddrBits-1:0] loadAddress,
    output logic [31:0]            loadData,
    output logic                   holdCpu,
    output logic [7:0]             bootLeds
);

    loaderStateT          state;
    logic [HoldBits-1:0]  holdCount;
    logic [RamAddrBits:0] remaining;

    always_ff @(posedge CPUClock or negedge rstN) begin
        if (!rstN) begin
            state       <= loaderWait;
            holdCount   <= '0;
            remaining   <= '0;
            start       <= 1'b0;
            wordAddress <= '0;
            loadWrite   <= 1'b0;
            holdCpu     <= 1'b1;
        end else begin
            start     <= 1'b0;
            loadWrite <= 1'b0;
            case (state)
                loaderWait: begin
                    if (holdCount != HoldBits'(ResetHoldCycles - 1)) begin
                        holdCount <= holdCount + 1'b1;
                    end else if (!busy) begin
                        // Card word 0 holds the image length
                        wordAddress <= '0;
                        start       <= 1'b1;
                        state       <= loaderSize;
                    end
                end
                loaderSize: begin
                    if (wordValid) begin
                        if (wordData == '0) begin
                            state <= loaderRun;
                        end else if (!busy) begin
                            remaining   <= wordData[RamAddrBits:0];
                            wordAddress <= 32'd1;
                            start       <= 1'b1;
                            state       <= loaderWords;
                        end
                    end
                end
                loaderWords: begin
                    if (wordValid) begin
                        loadWrite <= 1'b1;
                        remaining <= remaining - 1'b1;
                        if (remaining == 1) begin
                            state <= loaderRun;
                        end else if (!busy) begin
                            wordAddress <= wordAddress + 1'b1;
                            start       <= 1'b1;
                        end
                    end
                end
                // One cycle after the last write the bus goes to the processor
                loaderRun: holdCpu <= 1'b0;
                default: state <= loaderRun;
            endcase
        end
    end

    // Card word k lands in RAM word k-1
    always_ff @(posedge CPUClock) begin
        if (state == loaderWords && wordValid) begin
            loadAddress <= wordAddress[RamAddrBits-1:0] - 1'b1;
            loadData    <= wordData;
        end
    end

    always_comb begin
        case (state)
            loaderWait: bootLeds = LedWaitPattern;
            loaderSize: bootLeds = LedSizePattern;
            default:    bootLeds = LedLoadPattern;
        endcase
    end

    // Image must fit into the word RAM
    assert property (@(posedge CPUClock) disable iff (!rstN)
        (state == loaderSize && wordValid) |-> wordData <= RamWords);

endmodule

//--- verilog/sdWordReader.sv
`timescale 1ns/1ns

module sdWordReader import systemPkg::*; (
    input  logic        CPUClock,
    input  logic        rstN,
    input  logic        start,
    input  logic [31:0] wordAddress,
    output logic        busy,
    output logic        wordValid,
    output logic [31:0] wordData,
    output logic        sdCs,
    output logic        sdClk,
    output logic        sdMosi,
    input  logic        sdMiso
);

    readerStateT state;
    logic [39:0] cmdShift;
    logic [31:0] rxShift;
    logic [5:0]  bitCount;
    logic        sampleEdge;

    // Opcode and address leave MSB first
    assign sdMosi = cmdShift[39];

    // sdClk is about to rise during the data phase
    assign sampleEdge = (state == readerData) && !sdClk;

    always_ff @(posedge CPUClock or negedge rstN) begin
        if (!rstN) begin
            state     <= readerIdle;
            busy      <= 1'b0;
            wordValid <= 1'b0;
            sdCs      <= 1'b1;
            sdClk     <= 1'b0;
            cmdShift  <= '1;
            bitCount  <= '0;
        end else begin
            wordValid <= 1'b0;
            case (state)
                readerIdle: begin
                    if (start) begin
                        busy     <= 1'b1;
                        cmdShift <= {SdReadOpcode, wordAddress};
                        state    <= readerSelect;
                    end
                end
                readerSelect: begin
                    sdCs     <= 1'b0;
                    bitCount <= '0;
                    state    <= readerCommand;
                end
                readerCommand: begin
                    if (!sdClk) begin
                        sdClk <= 1'b1;
                    end else begin
                        // Falling edge, next command bit
                        sdClk    <= 1'b0;
                        cmdShift <= {cmdShift[38:0], 1'b1};
                        if (bitCount == 6'd39) begin
                            bitCount <= '0;
                            state    <= readerData;
                        end else begin
                            bitCount <= bitCount + 1'b1;
                        end
                    end
                end
                readerData: begin
                    if (!sdClk) begin
                        sdClk <= 1'b1;
                    end else begin
                        sdClk <= 1'b0;
                        if (bitCount == 6'd31) begin
                            state <= readerFinish;
                        end else begin
                            bitCount <= bitCount + 1'b1;
                        end
                    end
                end
                readerFinish: begin
                    sdCs      <= 1'b1;
                    busy      <= 1'b0;
                    wordValid <= 1'b1;
                    state     <= readerIdle;
                end
                default: state <= readerIdle;
            endcase
        end
    end

    // Receive path
    always_ff @(posedge CPUClock) begin
        if (sampleEdge) begin
            rxShift <= {rxShift[30:0], sdMiso};
        end
        if (state == readerFinish) begin
            wordData <= rxShift;
        end
    end

    // The loader must wait for the previous word before asking again
    assert property (@(posedge CPUClock) disable iff (!rstN) start |-> !busy);

endmodule

//--- verilog/systemPkg.sv
package systemPkg;

    // Word RAM geometry
    localparam int RamWords    = 1024;
    localparam int RamAddrBits = 10;

    // Button port
    localparam int ButtonCount    = 7;
    // Lockout after an accepted change, short enough for simulation
    localparam int DebounceCycles = 16;
    localparam int DebounceBits   = $clog2(DebounceCycles + 1);

    // Settle time before the loader talks to the card
    localparam int ResetHoldCycles = 8;
    localparam int HoldBits        = $clog2(ResetHoldCycles + 1);

    // IO selects in the processor address
    localparam int IoButtonBit = 30;
    localparam int IoLedBit    = 29;

    // LED patterns per boot phase
    localparam logic [7:0] LedWaitPattern = 8'b0010_0100;
    localparam logic [7:0] LedSizePattern = 8'b0100_1001;
    localparam logic [7:0] LedLoadPattern = 8'b1001_0010;

    // Card command set of the simplified word protocol
    typedef enum logic [7:0] {
        SdReadOpcode = 8'h03
    } sdOpcodeT;

    typedef enum logic [1:0] {
        loaderWait,
        loaderSize,
        loaderWords,
        loaderRun
    } loaderStateT;

    typedef enum logic [2:0] {
        readerIdle,
        readerSelect,
        readerCommand,
        readerData,
        readerFinish
    } readerStateT;

endpackage
